// File: tb.f
+incdir+hdl
hdl/arb_types_pkg.sv
hdl/arb_ctrl_pkg.sv
hdl/pixel_level.sv
hdl/pixel_groups.sv
hdl/pixel_hit_store.sv
hdl/readout_ctrl.sv
hdl/pixel_arbiter_top.sv
tb/tb_clkgen.sv
tb/tb_pixel_arbiter.sv

// File: tb/tb_pixel_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "arb_consts.svh"

module tb_pixel_arbiter;

   import arb_types_pkg::*;

   localparam int MAX_CYCLES = 3000;

   logic                                clk;
   logic                                rst_n;
   logic [`ARB_ROWS-1:0][`ARB_COLS-1:0] hit;
   logic                                readout_en;
   logic                                stall;
   logic                                event_valid;
   coord_t                              event_x;
   coord_t                              event_y;

   // reference model state
   logic [`ARB_ROWS-1:0][`ARB_COLS-1:0] m_pend = '0;
   logic [`ARB_ROWS-1:0][`ARB_COLS-1:0] seen;
   logic [1:0] ptr_l0 [16];
   logic [1:0] ptr_l1 [4];
   logic [1:0] ptr_rt = '0;
   logic       m_scan = 1'b0;
   logic       exp_valid = 1'b0;
   coord_t     exp_x;
   coord_t     exp_y;
   coord_t     last_x;
   coord_t     last_y;

   string test_name;
   int    cycle_cnt = 0;
   int    test_errs, total_errs, tests_run, tests_failed, n_checks;
   int    ev_count, dup_count, accepted;

   tb_clkgen #(.PERIOD_NS(100), .RESET_CYCLES(8)) u_clkgen (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   pixel_arbiter_top dut0 (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .hit_i         (hit),
      .readout_en_i  (readout_en),
      .stall_i       (stall),
      .event_valid_o (event_valid),
      .event_x_o     (event_x),
      .event_y_o     (event_y)
   );

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Regression failed");
         $finish;
      end
   end

   // first requesting raster index at or after ptr
   function automatic logic [1:0] rr_pick(input logic [3:0] req, input logic [1:0] ptr);
      logic [1:0] idx;
      rr_pick = ptr;
      for (int k = 3; k >= 0; k--) begin
         idx = ptr + 2'(k);
         if (req[idx]) begin
            rr_pick = idx;
         end
      end
   endfunction

   // predicts the serve at the coming edge and advances the model past it
   task automatic model_eval();
      logic [3:0][3:0]                     r0;
      logic [3:0]                          q_rt, q_l1, q_l0;
      logic [1:0]                          g_rt, g_l1, g_l0;
      logic [`ARB_ROWS-1:0][`ARB_COLS-1:0] clr;
      logic                                rel0, rel1;
      int                                  tr, tc;
      r0   = '0;
      q_rt = '0;
      clr  = '0;
      for (int r = 0; r < 8; r++) begin
         for (int c = 0; c < 8; c++) begin
            if (m_pend[r][c]) begin
               r0[r / 2][c / 2] = 1'b1;
            end
         end
      end
      for (int r = 0; r < 4; r++) begin
         for (int c = 0; c < 4; c++) begin
            if (r0[r][c]) begin
               q_rt[(r / 2) * 2 + c / 2] = 1'b1;
            end
         end
      end
      exp_valid = m_scan && !stall && (q_rt != '0);
      if (exp_valid) begin
         g_rt = rr_pick(q_rt, ptr_rt);
         for (int k = 0; k < 4; k++) begin
            q_l1[k] = r0[int'(g_rt[1]) * 2 + k / 2][int'(g_rt[0]) * 2 + k % 2];
         end
         g_l1 = rr_pick(q_l1, ptr_l1[g_rt]);
         tr = int'(g_rt[1]) * 2 + int'(g_l1[1]);
         tc = int'(g_rt[0]) * 2 + int'(g_l1[0]);
         for (int k = 0; k < 4; k++) begin
            q_l0[k] = m_pend[tr * 2 + k / 2][tc * 2 + k % 2];
         end
         g_l0 = rr_pick(q_l0, ptr_l0[tr * 4 + tc]);
         exp_x = coord_t'(tc * 2 + int'(g_l0[0]));
         exp_y = coord_t'(tr * 2 + int'(g_l0[1]));
         clr[exp_y][exp_x] = 1'b1;
         // a pixel is exhausted once served, a group once its last child is
         rel0 = ($countones(q_l0) == 1);
         rel1 = rel0 && ($countones(q_l1) == 1);
         ptr_l0[tr * 4 + tc] = g_l0 + 2'd1;
         ptr_l1[g_rt] = rel0 ? g_l1 + 2'd1 : g_l1;
         ptr_rt = rel1 ? g_rt + 2'd1 : g_rt;
      end
      accepted += $countones(hit & ~(m_pend & ~clr));
      m_pend = (m_pend & ~clr) | hit;
      m_scan = readout_en;
   endtask

   task automatic check_outputs();
      n_checks++;
      if (event_valid !== exp_valid) begin
         $display("[ERROR] %s: event_valid expected %0b actual %0b",
                  test_name, exp_valid, event_valid);
         test_errs++;
      end else if (exp_valid) begin
         if (event_x !== exp_x || event_y !== exp_y) begin
            $display("[ERROR] %s: event (x,y) expected (%0d,%0d) actual (%0d,%0d)",
                     test_name, exp_x, exp_y, event_x, event_y);
            test_errs++;
         end
      end
      if (event_valid === 1'b1) begin
         ev_count++;
         last_x = event_x;
         last_y = event_y;
         if (seen[event_y][event_x]) begin
            dup_count++;
         end
         seen[event_y][event_x] = 1'b1;
      end
   endtask

   // one clock: check what the last edge produced, then drive the next inputs
   task automatic step(input logic [63:0] hit_v, input logic stall_v, input logic en_v);
      @(posedge clk);
      #1;
      check_outputs();
      hit        = hit_v;
      stall      = stall_v;
      readout_en = en_v;
      model_eval();
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_errs = 0;
      ev_count  = 0;
      dup_count = 0;
      accepted  = 0;
      seen      = '0;
   endtask

   task automatic expect_count(input string what, input int expected, input int actual);
      if (expected != actual) begin
         $display("[ERROR] %s: %s expected %0d actual %0d", test_name, what, expected, actual);
         test_errs++;
      end
   endtask

   task automatic end_test();
      tests_run++;
      total_errs += test_errs;
      if (test_errs != 0) begin
         tests_failed++;
      end
      $display("test %s finished: %0d events, %0d errors", test_name, ev_count, test_errs);
   endtask

   initial begin
      logic [63:0] mask;
      int          r, c, n;
      hit        = '0;
      stall      = 1'b0;
      readout_en = 1'b0;
      void'($urandom(32'h164f));
      for (int k = 0; k < 16; k++) begin
         ptr_l0[k] = '0;
      end
      for (int k = 0; k < 4; k++) begin
         ptr_l1[k] = '0;
      end
      wait (rst_n === 1'b1);

      begin_test("reset_idle");
      repeat (20) step('0, 1'b0, 1'b1);
      expect_count("event count", 0, ev_count);
      end_test();

      begin_test("single_hit");
      r = $urandom % 8;
      c = $urandom % 8;
      mask = '0;
      mask[r * 8 + c] = 1'b1;
      step(mask, 1'b0, 1'b1);
      n = 0;
      while (ev_count == 0 && n < 20) begin
         step('0, 1'b0, 1'b1);
         n++;
      end
      if (ev_count == 0) begin
         $display("single_hit: no event appeared for the hit at column %0d row %0d", c, r);
         test_errs++;
      end
      repeat (8) step('0, 1'b0, 1'b1);
      expect_count("event count", 1, ev_count);
      expect_count("column", c, last_x);
      expect_count("row", r, last_y);
      end_test();

      begin_test("all_pixels");
      step('1, 1'b0, 1'b1);
      n = 0;
      while (ev_count == 0 && n < 20) begin
         step('0, 1'b0, 1'b1);
         n++;
      end
      // from the first event on, every cycle must carry one
      n = 1;
      while (ev_count < 64 && n < 64) begin
         step('0, 1'b0, 1'b1);
         n++;
      end
      repeat (4) step('0, 1'b0, 1'b1);
      expect_count("event count", 64, ev_count);
      expect_count("repeated pixels", 0, dup_count);
      end_test();

      begin_test("stall_and_disable");
      mask = {$urandom, $urandom};
      step(mask, 1'b1, 1'b1);
      repeat (29) step('0, 1'b1, 1'b1);
      step('0, 1'b1, 1'b0);
      repeat (29) step('0, 1'b0, 1'b0);
      expect_count("events while held", 0, ev_count);
      n = 0;
      while (ev_count < $countones(mask) && n < 150) begin
         step('0, 1'b0, 1'b1);
         n++;
      end
      repeat (4) step('0, 1'b0, 1'b1);
      expect_count("event count", $countones(mask), ev_count);
      expect_count("repeated pixels", 0, dup_count);
      end_test();

      begin_test("random_traffic");
      for (int i = 0; i < 1000; i++) begin
         mask = '0;
         r = $urandom % 3;
         c = $urandom % 64;
         if (r == 0) begin
            mask[c] = 1'b1;
         end
         if ($urandom % 50 == 0) begin
            mask = mask | {$urandom, $urandom};
         end
         step(mask, ($urandom % 5) == 0, ($urandom % 12) != 0);
      end
      n = 0;
      while (m_pend != '0 && n < 200) begin
         step('0, 1'b0, 1'b1);
         n++;
      end
      repeat (3) step('0, 1'b0, 1'b1);
      expect_count("events against accepted hits", accepted, ev_count);
      end_test();

      $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, n_checks, total_errs);
      if (total_errs == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 8
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk_o = ~clk_o;
      end
   end

   // release just after an edge so no edge sees it change
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1;
      rst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

// File: hdl/pixel_arbiter_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "arb_consts.svh"

module pixel_arbiter_top (
   input  wire                                     clk_i,
   input  wire                                     rst_n_i,
   input  wire  [`ARB_ROWS-1:0][`ARB_COLS-1:0]     hit_i,
   input  wire                                     readout_en_i,
   input  wire                                     stall_i,
   output logic                                    event_valid_o,
   output arb_types_pkg::coord_t                   event_x_o,
   output arb_types_pkg::coord_t                   event_y_o
);

   import arb_types_pkg::*;

   localparam int L1_ROWS = `ARB_ROWS / `ARB_TILE;
   localparam int L1_COLS = `ARB_COLS / `ARB_TILE;
   localparam int RT_ROWS = L1_ROWS / `ARB_TILE;
   localparam int RT_COLS = L1_COLS / `ARB_TILE;

   logic [`ARB_ROWS-1:0][`ARB_COLS-1:0] pending;
   logic [`ARB_ROWS-1:0][`ARB_COLS-1:0] l0_gnt;
   logic [L1_ROWS-1:0][L1_COLS-1:0]     l0_req;
   logic [L1_ROWS-1:0][L1_COLS-1:0]     l1_gnt;
   logic [RT_ROWS-1:0][RT_COLS-1:0]     l1_req;
   logic [RT_ROWS-1:0][RT_COLS-1:0]     root_gnt;
   sub_addr_t l0_x, l0_y, l1_x, l1_y, root_x, root_y;
   logic      l0_rel, l1_rel;
   logic      scan, serve, root_active;
   coord_t    col, row;

   // root bit first, level 0 bit last
   assign col = {root_x, l1_x, l0_x};
   assign row = {root_y, l1_y, l0_y};

   pixel_hit_store u_hits (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .hit_i     (hit_i),
      .clear_i   (l0_gnt),
      .serve_i   (serve),
      .pending_o (pending)
   );

   // level 0, pixels in 2x2 tiles; a served pixel is always exhausted
   pixel_groups #(.ROWS(`ARB_ROWS), .COLS(`ARB_COLS)) u_lvl0 (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .req_i           (pending),
      .enable_i        (l1_gnt),
      .grp_enable_i    (serve),
      .child_release_i (serve),
      .req_o           (l0_req),
      .gnt_out_o       (l0_gnt),
      .x_add_o         (l0_x),
      .y_add_o         (l0_y),
      .active_o        (),
      .grp_release_o   (l0_rel)
   );

   pixel_groups #(.ROWS(L1_ROWS), .COLS(L1_COLS)) u_lvl1 (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .req_i           (l0_req),
      .enable_i        (root_gnt),
      .grp_enable_i    (serve),
      .child_release_i (l0_rel),
      .req_o           (l1_req),
      .gnt_out_o       (l1_gnt),
      .x_add_o         (l1_x),
      .y_add_o         (l1_y),
      .active_o        (),
      .grp_release_o   (l1_rel)
   );

   pixel_level u_root (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .req_i           (l1_req),
      .enable_i        (scan),
      .grp_enable_i    (serve),
      .child_release_i (l1_rel),
      .req_o           (),
      .gnt_o           (root_gnt),
      .x_add_o         (root_x),
      .y_add_o         (root_y),
      .active_o        (root_active),
      .grp_release_o   ()
   );

   readout_ctrl u_readout (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .readout_en_i  (readout_en_i),
      .stall_i       (stall_i),
      .root_active_i (root_active),
      .col_i         (col),
      .row_i         (row),
      .scan_o        (scan),
      .serve_o       (serve),
      .event_valid_o (event_valid_o),
      .event_x_o     (event_x_o),
      .event_y_o     (event_y_o)
   );

endmodule

`default_nettype wire

// File: hdl/readout_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module readout_ctrl (
   input  wire                    clk_i,
   input  wire                    rst_n_i,
   input  wire                    readout_en_i,
   input  wire                    stall_i,
   input  wire                    root_active_i,
   input  wire arb_types_pkg::coord_t col_i,
   input  wire arb_types_pkg::coord_t row_i,
   output logic                   scan_o,
   output logic                   serve_o,
   output logic                   event_valid_o,
   output arb_types_pkg::coord_t  event_x_o,
   output arb_types_pkg::coord_t  event_y_o
);

   import arb_ctrl_pkg::*;

   ro_state_t state_q;

   // follows readout_en_i one edge late
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= RO_IDLE;
      end else begin
         state_q <= readout_en_i ? RO_SCAN : RO_IDLE;
      end
   end

   assign scan_o  = (state_q == RO_SCAN);
   assign serve_o = scan_o & ~stall_i & root_active_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         event_valid_o <= 1'b0;
      end else begin
         event_valid_o <= serve_o;
      end
   end

   // event coordinates held between serves
   always_ff @(posedge clk_i) begin
      if (serve_o) begin
         event_x_o <= col_i;
         event_y_o <= row_i;
      end
   end

endmodule

`default_nettype wire

// File: hdl/pixel_hit_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "arb_consts.svh"

module pixel_hit_store (
   input  wire                                     clk_i,
   input  wire                                     rst_n_i,
   input  wire  [`ARB_ROWS-1:0][`ARB_COLS-1:0]     hit_i,
   input  wire  [`ARB_ROWS-1:0][`ARB_COLS-1:0]     clear_i,
   input  wire                                     serve_i,
   output logic [`ARB_ROWS-1:0][`ARB_COLS-1:0]     pending_o
);

   logic [`ARB_ROWS-1:0][`ARB_COLS-1:0] clr_mask;

   // clear only on a real serve
   assign clr_mask = serve_i ? clear_i : '0;

   // a fresh hit overrides the clear of the same pixel
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pending_o <= '0;
      end else begin
         pending_o <= (pending_o & ~clr_mask) | hit_i;
      end
   end

   // the tree only ever grants one pixel that is waiting
   a_serve_pending : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      serve_i |-> ($onehot(clear_i) && ((clear_i & ~pending_o) == '0))
   ) else $error("pixel_hit_store: served pixel was not pending");

endmodule

`default_nettype wire

// File: hdl/pixel_groups.sv
`timescale 1ns/1ps
`default_nettype none

`include "arb_consts.svh"

module pixel_groups #(
   parameter int ROWS = `ARB_ROWS,
   parameter int COLS = `ARB_COLS
) (
   input  wire                                              clk_i,
   input  wire                                              rst_n_i,
   input  wire  [ROWS-1:0][COLS-1:0]                        req_i,
   input  wire  [ROWS/`ARB_TILE-1:0][COLS/`ARB_TILE-1:0]    enable_i,
   input  wire                                              grp_enable_i,
   input  wire                                              child_release_i,
   output logic [ROWS/`ARB_TILE-1:0][COLS/`ARB_TILE-1:0]    req_o,
   output logic [ROWS-1:0][COLS-1:0]                        gnt_out_o,
   output arb_types_pkg::sub_addr_t                         x_add_o,
   output arb_types_pkg::sub_addr_t                         y_add_o,
   output logic                                             active_o,
   output logic                                             grp_release_o
);

   import arb_types_pkg::*;

   localparam int T         = `ARB_TILE;
   localparam int GR        = ROWS / T;
   localparam int GC        = COLS / T;
   localparam int NUM_CELLS = GR * GC;

   // cell g covers tile row g/GC, tile col g%GC
   logic [NUM_CELLS-1:0][T-1:0][T-1:0] cell_req;
   wire  [NUM_CELLS-1:0][T-1:0][T-1:0] cell_gnt;
   wire  sub_addr_t [NUM_CELLS-1:0]    cell_x;
   wire  sub_addr_t [NUM_CELLS-1:0]    cell_y;
   wire  [NUM_CELLS-1:0]               cell_req_o;
   wire  [NUM_CELLS-1:0]               cell_active;
   wire  [NUM_CELLS-1:0]               cell_rel;
   logic [NUM_CELLS-1:0]               en_flat;

   assign en_flat  = enable_i;
   assign req_o    = cell_req_o;
   assign active_o = |cell_active;

   // cut the map into tiles and put each tile grant back in place
   always_comb begin
      for (int g = 0; g < NUM_CELLS; g++) begin
         for (int r = 0; r < T; r++) begin
            for (int c = 0; c < T; c++) begin
               cell_req[g][r][c] = req_i[(g / GC) * T + r][(g % GC) * T + c];
               gnt_out_o[(g / GC) * T + r][(g % GC) * T + c] = cell_gnt[g][r][c];
            end
         end
      end
   end

   for (genvar g = 0; g < NUM_CELLS; g++) begin : g_cell
      pixel_level u_cell (
         .clk_i           (clk_i),
         .rst_n_i         (rst_n_i),
         .req_i           (cell_req[g]),
         .enable_i        (en_flat[g]),
         .grp_enable_i    (grp_enable_i),
         .child_release_i (child_release_i),
         .req_o           (cell_req_o[g]),
         .gnt_o           (cell_gnt[g]),
         .x_add_o         (cell_x[g]),
         .y_add_o         (cell_y[g]),
         .active_o        (cell_active[g]),
         .grp_release_o   (cell_rel[g])
      );
   end

   // only the cell picked by the parent reports upward
   always_comb begin
      x_add_o       = '0;
      y_add_o       = '0;
      grp_release_o = 1'b0;
      for (int g = 0; g < NUM_CELLS; g++) begin
         if (en_flat[g]) begin
            x_add_o       = cell_x[g];
            y_add_o       = cell_y[g];
            grp_release_o = cell_rel[g];
         end
      end
   end

   // parent grant selects one tile at most
   a_enable_onehot : assert property (
      @(posedge clk_i) disable iff (!rst_n_i) $onehot0(en_flat)
   ) else $error("pixel_groups: several tiles enabled %b", en_flat);

endmodule

`default_nettype wire

// File: hdl/pixel_level.sv
`timescale 1ns/1ps
`default_nettype none

`include "arb_consts.svh"

module pixel_level (
   input  wire                                    clk_i,
   input  wire                                    rst_n_i,
   input  wire  [`ARB_TILE-1:0][`ARB_TILE-1:0]    req_i,
   input  wire                                    enable_i,
   input  wire                                    grp_enable_i,
   input  wire                                    child_release_i,
   output logic                                   req_o,
   output logic [`ARB_TILE-1:0][`ARB_TILE-1:0]    gnt_o,
   output arb_types_pkg::sub_addr_t               x_add_o,
   output arb_types_pkg::sub_addr_t               y_add_o,
   output logic                                   active_o,
   output logic                                   grp_release_o
);

   import arb_types_pkg::*;

   localparam int NREQ = `ARB_TILE * `ARB_TILE;

   // raster view of the 2x2 request tile with bit index row*2 + col
   logic [NREQ-1:0] req_flat;
   logic [NREQ-1:0] gnt_flat;
   rr_ptr_t         ptr_q;
   rr_ptr_t         gnt_idx;
   rr_ptr_t         scan_idx;
   logic            found;
   logic            last_req;

   assign req_flat = req_i;
   assign req_o    = |req_flat;
   assign active_o = enable_i & req_o;

   // first request at or after the pointer with wraparound
   always_comb begin
      gnt_idx  = ptr_q;
      found    = 1'b0;
      scan_idx = ptr_q;
      for (int k = 0; k < NREQ; k++) begin
         scan_idx = ptr_q + rr_ptr_t'(k);
         if (!found && req_flat[scan_idx]) begin
            gnt_idx = scan_idx;
            found   = 1'b1;
         end
      end
   end

   assign gnt_flat = active_o ? (NREQ'(1) << gnt_idx) : '0;
   assign gnt_o    = gnt_flat;

   assign x_add_o = gnt_idx[0];
   assign y_add_o = gnt_idx[1];

   // nothing else waiting in this cell once the grant is taken
   assign last_req      = ((req_flat & ~gnt_flat) == '0);
   assign grp_release_o = grp_enable_i & active_o & child_release_i & last_req;

   // stay on the granted child until it releases, then step past it
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ptr_q <= '0;
      end else if (grp_enable_i && active_o) begin
         if (child_release_i) begin
            ptr_q <= rr_ptr_t'(gnt_idx + 2'd1);
         end else begin
            ptr_q <= gnt_idx;
         end
      end
   end

   // a child that has not released still waits, so the locked grant holds
   a_lock_hold : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (grp_enable_i && active_o && !child_release_i)
         |=> (!active_o || (gnt_o == $past(gnt_o)))
   ) else $error("pixel_level: locked grant moved while the child still waits");

endmodule

`default_nettype wire

// File: hdl/arb_ctrl_pkg.sv
`default_nettype none

package arb_ctrl_pkg;

   // readout controller states
   typedef enum logic [0:0] {
      RO_IDLE = 1'b0,
      RO_SCAN = 1'b1
   } ro_state_t;

endpackage

`default_nettype wire

// File: hdl/arb_types_pkg.sv
`default_nettype none

`include "arb_consts.svh"

package arb_types_pkg;

   // column or row of one pixel in the array
   typedef logic [`ARB_ADDR_BITS-1:0] coord_t;

   // x or y position inside one 2x2 cell
   typedef logic [`ARB_LVL_BITS-1:0] sub_addr_t;

   // raster index 0..3 inside a cell, y in the upper bit
   typedef logic [2*`ARB_LVL_BITS-1:0] rr_ptr_t;

endpackage

`default_nettype wire

// File: hdl/arb_consts.svh
`ifndef ARB_CONSTS_SVH
`define ARB_CONSTS_SVH

// pixel array geometry
`define ARB_ROWS 8
`define ARB_COLS 8

// side of the group one arbitration cell covers
`define ARB_TILE 2

// sub-address width contributed by one tree level
`define ARB_LVL_BITS 1

// full pixel coordinate, one sub-address bit per level
`define ARB_ADDR_BITS 3

`endif
